// ==== crc8_atm_x32.sv ====
`default_nettype none

`include "sccb_rx_defines.svh"

module crc8_atm_x32 import sccb_rx_pkg::*; (
	input wire rx_clk,
	input wire rst,
	input wire crc_req_t req,
	output logic [7:0] crc
);

	logic [7:0] crc_next;

	////////////////////////////////////////
	// One byte through x^8+x^2+x+1

	// MSB first, no reflection
	function automatic logic [7:0] crc8_byte(
		input logic [7:0] crc_in,
		input logic [7:0] din
	);
		logic [7:0] c;
		c = crc_in ^ din;
		for (int b = 0; b < 8; b++) begin
			c = c[7] ? ((c << 1) ^ 8'h07) : (c << 1);
		end
		return c;
	endfunction

	////////////////////////////////////////
	// Fold up to four bytes per clock

	always_comb begin
		// Restart drops the old value, this word still counts
		crc_next = req.restart ? 8'h00 : crc;

		// Lane 0 goes in first, unused upper lanes skipped
		for (int i = 0; i < `SCCB_SYMBOLS; i++) begin
			if (req.len > 3'(i)) begin
				crc_next = crc8_byte(crc_next, req.din[i*8 +: 8]);
			end
		end
	end

	// Result valid the cycle after the request
	always_ff @(posedge rx_clk) begin
		if (rst) begin
			crc <= 8'h00;
		end else begin
			crc <= crc_next;
		end
	end

	// More than one word of bytes per clock is never requested
	a_len_range: assert property (@(posedge rx_clk) disable iff (rst)
		req.len <= 3'(`SCCB_SYMBOLS))
		else $error("CRC request length %0d out of range", req.len);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SCCB receive testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

# Compile RTL and testbench into one binary
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_sccb_rx -f tb.f -o tb_sccb_rx_sim > "$build_log" 2>&1
if [ $? -ne 0 ]; then
	cat "$build_log"
	echo "Verilator build failed"
	exit 1
fi

# Run from the project root so the data file is found
./obj_dir/tb_sccb_rx_sim > "$sim_log" 2>&1
run_status=$?
cat "$sim_log"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

# Verdict comes from the log
grep -q "STATUS: FAIL" "$sim_log"
grep_status=$?
if [ $grep_status -eq 0 ]; then
	exit 1
fi
if [ $grep_status -ne 1 ]; then
	echo "could not search $sim_log"
	exit 1
fi
exit 0

// ==== sccb_frame_check.sv ====
`default_nettype none

module sccb_frame_check import sccb_rx_pkg::*; (
	input wire rx_clk,
	input wire rst,
	input wire crc_req_t crc_req,
	input wire csum_load_t csum_load,
	input wire frame_done,
	input wire frame_malformed,
	output logic commit,
	output logic drop
);

	logic [7:0] crc;
	logic [7:0] expected_q;

	////////////////////////////////////////
	// Running CRC of the payload

	crc8_atm_x32 crc8_atm_x32_inst (
		.rx_clk (rx_clk),
		.rst    (rst),
		.req    (crc_req),
		.crc    (crc)
	);

	// Checksum byte from the stop word or the word after
	always_ff @(posedge rx_clk) begin
		if (csum_load.load) begin
			expected_q <= csum_load.value;
		end
	end

	////////////////////////////////////////
	// Frame verdict

	// Done lines up with the last CRC update
	always_comb begin
		commit = frame_done && (crc == expected_q);
	end

	// Bad checksum or bad stop lane
	always_ff @(posedge rx_clk) begin
		if (rst) begin
			drop <= 1'b0;
		end else begin
			drop <= frame_malformed || (frame_done && (crc != expected_q));
		end
	end

	// One verdict per frame, never both
	a_one_verdict: assert property (@(posedge rx_clk) disable iff (rst)
		!(commit && drop))
		else $error("Commit and drop in the same cycle");

endmodule

`default_nettype wire

// ==== sccb_link_monitor.sv ====
`default_nettype none

`include "sccb_rx_defines.svh"

module sccb_link_monitor import sccb_rx_pkg::*; (
	input wire rx_clk,
	input wire rst,
	input wire serdes_word_t rx_in,
	input wire rx_data_valid,
	input wire frame_error,
	output logic link_up
);

	logic is_idle;
	logic idle_q;
	logic [7:0] idle_count;
	logic [7:0] error_count;

	// Idle word is K28.5 D21.5 then D0.0 in the upper lanes
	always_comb begin
		is_idle = (rx_in.kchar == 4'b0001) &&
			(rx_in.data == {16'h0000, `SCCB_IDLE_D, `SCCB_IDLE_CODE});
	end

	////////////////////////////////////////
	// Training and error tracking

	always_ff @(posedge rx_clk) begin
		if (rst) begin
			idle_q      <= 1'b0;
			idle_count  <= 8'd0;
			error_count <= 8'd0;
			link_up     <= 1'b0;
		end else if (rx_data_valid) begin
			// Match flag lags the word by one
			idle_q <= is_idle;

			if (link_up) begin
				// Stray stop codes and bad lane 0 words
				if (frame_error) begin
					error_count <= error_count + 8'd1;
				end

				// Too many errors, back to training
				if (error_count == 8'(`SCCB_ERROR_LIMIT)) begin
					link_up    <= 1'b0;
					idle_count <= 8'd0;
				end
			end else if (idle_q) begin
				idle_count <= idle_count + 8'd1;

				// Long enough run, link comes up with a clean error count
				if (idle_count == 8'(`SCCB_LINK_UP_IDLES)) begin
					link_up     <= 1'b1;
					error_count <= 8'd0;
				end
			end else begin
				// Run broken, start over
				idle_count <= 8'd0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== sccb_rx_defines.svh ====
`ifndef SCCB_RX_DEFINES_SVH
`define SCCB_RX_DEFINES_SVH

////////////////////////////////////////
// Datapath geometry

// Four 8b/10b symbols per SERDES word
`define SCCB_SYMBOLS 4
`define SCCB_WORD_BITS 32

////////////////////////////////////////
// Control characters

// K28.5, lane 0 of an idle word
`define SCCB_IDLE_CODE 8'hbc
// K28.6, end of frame in any lane
`define SCCB_STOP_CODE 8'hdc
// K30.7, link layer control, ignored on receive
`define SCCB_LLCTL_CODE 8'hfe
// D21.5, lane 1 of an idle word
`define SCCB_IDLE_D 8'hb5

////////////////////////////////////////
// Link training

// Idle run count at which the link comes up
`define SCCB_LINK_UP_IDLES 255
// Framing errors that take the link down
`define SCCB_ERROR_LIMIT 64

`endif

// ==== sccb_rx_framer.sv ====
`default_nettype none

`include "sccb_rx_defines.svh"

module sccb_rx_framer import sccb_rx_pkg::*; (
	input wire rx_clk,
	input wire rst,
	input wire serdes_word_t rx_in,
	input wire rx_data_valid,
	input wire link_up,
	output ll_word_t rx_ll,
	output crc_req_t crc_req,
	output csum_load_t csum_load,
	output logic frame_done,
	output logic frame_malformed,
	output logic frame_error
);

	// Frame state
	logic active_q;
	logic csum_due_q;
	logic done_next_q;

	// Next state
	logic active_d;
	logic csum_due_d;
	logic done_next_d;
	logic done_d;
	ll_word_t ll_d;

	logic [7:0] lane0;

	assign lane0 = rx_in.data[7:0];

	////////////////////////////////////////
	// Word decode

	always_comb begin
		crc_req         = '0;
		crc_req.din     = rx_in.data;
		csum_load       = '0;
		frame_malformed = 1'b0;
		frame_error     = 1'b0;
		ll_d            = '0;
		active_d        = active_q;
		csum_due_d      = csum_due_q;
		done_next_d     = 1'b0;
		done_d          = done_next_q;

		if (rx_data_valid) begin
			if (csum_due_q) begin
				// Checksum word after a lane 3 stop or an ACK
				csum_load.load  = 1'b1;
				csum_load.value = rx_in.data[7:0];
				csum_due_d      = 1'b0;
				done_d          = 1'b1;
			end else if (active_q) begin
				// Lowest K lane is where the stop code must sit
				casez (rx_in.kchar)
					4'b???1: begin
						// No payload left, CRC gets nothing
						active_d = 1'b0;
						if (lane0 == `SCCB_STOP_CODE) begin
							csum_load.load  = 1'b1;
							csum_load.value = rx_in.data[15:8];
							// CRC settled last word but wait a cycle like the other ends
							done_next_d     = 1'b1;
						end else begin
							frame_malformed = 1'b1;
						end
					end
					4'b??10: begin
						active_d    = 1'b0;
						crc_req.len = 3'd1;
						if (rx_in.data[15:8] == `SCCB_STOP_CODE) begin
							csum_load.load  = 1'b1;
							csum_load.value = rx_in.data[23:16];
							done_d          = 1'b1;
							ll_d.valid      = 1'b1;
							ll_d.nvalid     = 3'd1;
							ll_d.data       = {24'h0, rx_in.data[7:0]};
						end else begin
							frame_malformed = 1'b1;
						end
					end
					4'b?100: begin
						active_d    = 1'b0;
						crc_req.len = 3'd2;
						if (rx_in.data[23:16] == `SCCB_STOP_CODE) begin
							csum_load.load  = 1'b1;
							csum_load.value = rx_in.data[31:24];
							done_d          = 1'b1;
							ll_d.valid      = 1'b1;
							ll_d.nvalid     = 3'd2;
							ll_d.data       = {16'h0, rx_in.data[15:0]};
						end else begin
							frame_malformed = 1'b1;
						end
					end
					4'b1000: begin
						active_d    = 1'b0;
						crc_req.len = 3'd3;
						if (rx_in.data[31:24] == `SCCB_STOP_CODE) begin
							// Checksum rides in the next word
							csum_due_d  = 1'b1;
							ll_d.valid  = 1'b1;
							ll_d.nvalid = 3'd3;
							ll_d.data   = {8'h0, rx_in.data[23:0]};
						end else begin
							frame_malformed = 1'b1;
						end
					end
					default: begin
						// Plain data word, all four bytes
						crc_req.len = 3'd4;
						ll_d.valid  = 1'b1;
						ll_d.nvalid = 3'd4;
						ll_d.data   = rx_in.data;
					end
				endcase
			end else if (link_up) begin
				if (rx_in.kchar == 4'b0001) begin
					if (lane0 == `SCCB_STOP_CODE) begin
						// End of frame with no frame open
						frame_error = 1'b1;
					end else if (lane0 != `SCCB_IDLE_CODE && lane0 != `SCCB_LLCTL_CODE) begin
						// Start of frame, CRC skips the K char and sequence byte
						crc_req.restart = 1'b1;
						crc_req.len     = 3'd2;
						crc_req.din     = {16'h0, rx_in.data[31:16]};
						ll_d.start      = 1'b1;
						ll_d.valid      = 1'b1;
						ll_d.nvalid     = 3'd4;
						ll_d.data       = rx_in.data;
						active_d        = 1'b1;
					end
				end else if (rx_in.kchar == 4'b1001) begin
					// Single word ACK
					// start, sequence, status, stop, checksum next word
					crc_req.restart = 1'b1;
					crc_req.len     = 3'd1;
					crc_req.din     = {16'h0, rx_in.data[31:16]};
					ll_d.start      = 1'b1;
					ll_d.valid      = 1'b1;
					ll_d.nvalid     = 3'd3;
					ll_d.data       = {8'h0, rx_in.data[23:0]};
					csum_due_d      = 1'b1;
				end else begin
					// Anything without K in lane 0 alone
					frame_error = 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////
	// State and output registers

	always_ff @(posedge rx_clk) begin
		if (rst) begin
			active_q    <= 1'b0;
			csum_due_q  <= 1'b0;
			done_next_q <= 1'b0;
			frame_done  <= 1'b0;
			rx_ll       <= '0;
		end else begin
			active_q    <= active_d;
			csum_due_q  <= csum_due_d;
			done_next_q <= done_next_d;
			frame_done  <= done_d;
			rx_ll       <= ll_d;
		end
	end

	// A frame only opens from idle with the link trained
	a_start_link_up: assert property (@(posedge rx_clk) disable iff (rst)
		rx_ll.start |-> $past(link_up && !active_q))
		else $error("Frame start without link up");

endmodule

`default_nettype wire

// ==== sccb_rx_pkg.sv ====
`default_nettype none

`include "sccb_rx_defines.svh"

package sccb_rx_pkg;

	////////////////////////////////////////
	// Receive side word types

	// One word from the SERDES
	// One K flag per lane, lane 0 in the low byte
	typedef struct packed {
		logic [`SCCB_SYMBOLS-1:0]   kchar;
		logic [`SCCB_WORD_BITS-1:0] data;
	} serdes_word_t;

	// Word handed to the upper layer
	// nvalid counts bytes from the low end of data
	typedef struct packed {
		logic                       start;
		logic                       valid;
		logic [2:0]                 nvalid;
		logic [`SCCB_WORD_BITS-1:0] data;
	} ll_word_t;

	// Command to the CRC engine
	// restart seeds from zero before folding in din
	typedef struct packed {
		logic                       restart;
		logic [2:0]                 len;
		logic [`SCCB_WORD_BITS-1:0] din;
	} crc_req_t;

	// Received checksum byte and its capture strobe
	typedef struct packed {
		logic       load;
		logic [7:0] value;
	} csum_load_t;

endpackage

`default_nettype wire

// ==== sccb_rx_testdata.txt ====
# name count kchar data nvalid exp_data end link, kchar and both data columns in hex
# end is 0 none 1 commit 2 drop, link is 0 or 1 after the last repeat and 2 unchecked
idle_200 200 1 0000b5bc 0 00000000 0 0
idle_260 60 1 0000b5bc 0 00000000 0 1
# Payload bytes 01 02 03 04 05 06 07 08 09 give CRC 2f d8 3e 85 after 6 7 8 9 bytes
end_lane0 1 1 020110fb 4 020110fb 0 2
end_lane0 1 0 06050403 4 06050403 0 2
end_lane0 1 1 00002fdc 0 00000000 1 2
end_lane1 1 1 020111fb 4 020111fb 0 2
end_lane1 1 0 06050403 4 06050403 0 2
end_lane1 1 2 00d8dc07 1 00000007 1 2
end_lane2 1 1 020112fb 4 020112fb 0 2
end_lane2 1 0 06050403 4 06050403 0 2
end_lane2 1 4 3edc0807 2 00000807 1 2
end_lane3 1 1 020113fb 4 020113fb 0 2
end_lane3 1 0 06050403 4 06050403 0 2
end_lane3 1 8 dc090807 3 00090807 0 2
end_lane3 1 0 00000085 0 00000000 1 2
# Same frames with the checksum off by one
bad_lane0 1 1 020114fb 4 020114fb 0 2
bad_lane0 1 0 06050403 4 06050403 0 2
bad_lane0 1 1 00002edc 0 00000000 2 2
bad_lane1 1 1 020115fb 4 020115fb 0 2
bad_lane1 1 0 06050403 4 06050403 0 2
bad_lane1 1 2 00d9dc07 1 00000007 2 2
bad_lane2 1 1 020116fb 4 020116fb 0 2
bad_lane2 1 0 06050403 4 06050403 0 2
bad_lane2 1 4 3fdc0807 2 00000807 2 2
bad_lane3 1 1 020117fb 4 020117fb 0 2
bad_lane3 1 0 06050403 4 06050403 0 2
bad_lane3 1 8 dc090807 3 00090807 0 2
bad_lane3 1 0 00000084 0 00000000 2 2
# ACK status byte 01 gives CRC 07, stop lane with K28.5 is malformed
ack_frame 1 9 dc0120fb 3 000120fb 0 2
ack_frame 1 0 00000007 0 00000000 1 2
bad_stop 1 1 020118fb 4 020118fb 0 2
bad_stop 1 2 0000bc07 0 00000000 2 2
llctl_idle 1 1 000000fe 0 00000000 0 1
llctl_idle 20 1 0000b5bc 0 00000000 0 1
stray_64 64 1 000000dc 0 00000000 0 1
stray_70 6 1 000000dc 0 00000000 0 0

// ==== sccb_rx_top.sv ====
`default_nettype none

module sccb_rx_top import sccb_rx_pkg::*; (
	input wire rx_clk,
	input wire rst,
	input wire serdes_word_t rx_in,
	input wire rx_data_valid,
	output ll_word_t rx_ll,
	output logic rx_ll_link_up,
	output logic rx_ll_commit,
	output logic rx_ll_drop
);

	// Framer to monitor
	logic frame_error;

	// Framer to checker
	crc_req_t crc_req;
	csum_load_t csum_load;
	logic frame_done;
	logic frame_malformed;

	////////////////////////////////////////
	// Link training

	sccb_link_monitor sccb_link_monitor_inst (
		.rx_clk        (rx_clk),
		.rst           (rst),
		.rx_in         (rx_in),
		.rx_data_valid (rx_data_valid),
		.frame_error   (frame_error),
		.link_up       (rx_ll_link_up)
	);

	////////////////////////////////////////
	// Framing and payload

	sccb_rx_framer sccb_rx_framer_inst (
		.rx_clk          (rx_clk),
		.rst             (rst),
		.rx_in           (rx_in),
		.rx_data_valid   (rx_data_valid),
		.link_up         (rx_ll_link_up),
		.rx_ll           (rx_ll),
		.crc_req         (crc_req),
		.csum_load       (csum_load),
		.frame_done      (frame_done),
		.frame_malformed (frame_malformed),
		.frame_error     (frame_error)
	);

	////////////////////////////////////////
	// CRC check and verdict

	sccb_frame_check sccb_frame_check_inst (
		.rx_clk          (rx_clk),
		.rst             (rst),
		.crc_req         (crc_req),
		.csum_load       (csum_load),
		.frame_done      (frame_done),
		.frame_malformed (frame_malformed),
		.commit          (rx_ll_commit),
		.drop            (rx_ll_drop)
	);

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
sccb_rx_pkg.sv
crc8_atm_x32.sv
sccb_link_monitor.sv
sccb_rx_framer.sv
sccb_frame_check.sv
sccb_rx_top.sv
tb_sccb_rx.sv

// ==== tb_sccb_rx_tasks.svh ====
`ifndef TB_SCCB_RX_TASKS_SVH
`define TB_SCCB_RX_TASKS_SVH

////////////////////////////////////////
// Test bookkeeping

// One more error for the running test and for the run
task automatic note_error();
	err_total++;
	test_errors++;
endtask

// Result line once a test has drained
task automatic finish_test(input string name);
	tests_run++;
	if (test_errors == 0) begin
		$display("test %s passed", name);
	end else begin
		tests_failed++;
		$display("test %s failed with %0d errors", name, test_errors);
	end
	test_errors = 0;
endtask

////////////////////////////////////////
// Compare tasks

// Whole upper layer word with all fields at once
task automatic check_ll(input string name, input ll_word_t exp, input ll_word_t act);
	if (act !== exp) begin
		$display("[FAIL] %s rx_ll: expected start %b valid %b nvalid %0d data %h,",
			name, exp.start, exp.valid, exp.nvalid, exp.data,
			" actual start %b valid %b nvalid %0d data %h",
			act.start, act.valid, act.nvalid, act.data);
		note_error();
	end
endtask

// Single level such as link_up
task automatic check_bit(input string name, input string what, input logic exp,
	input logic act);
	if (act !== exp) begin
		$display("[FAIL] %s %s: expected %b actual %b", name, what, exp, act);
		note_error();
	end
endtask

// Code 1 wants one commit and code 2 one drop in the next four cycles
task automatic check_end(input string name, input int code);
	int commits_before;
	int drops_before;
	int exp_c;
	int exp_d;
	int got_c;
	int got_d;
	commits_before = commit_count;
	drops_before = drop_count;
	exp_c = (code == 1) ? 1 : 0;
	exp_d = (code == 2) ? 1 : 0;
	exp_commits += exp_c;
	exp_drops += exp_d;
	// Bus stays quiet while the verdict comes out
	repeat (4) drive_cycle('0, 1'b0, '0, 2);
	got_c = commit_count - commits_before;
	got_d = drop_count - drops_before;
	if (got_c != exp_c || got_d != exp_d) begin
		$display("[FAIL] %s verdict: expected commit %0d drop %0d,", name, exp_c, exp_d,
			" actual commit %0d drop %0d", got_c, got_d);
		note_error();
	end
endtask

// Pulses outside the verdict windows show up here
task automatic check_totals();
	if (commit_count != exp_commits || drop_count != exp_drops) begin
		$display("[FAIL] verdict_totals: expected commit %0d drop %0d,",
			exp_commits, exp_drops,
			" actual commit %0d drop %0d", commit_count, drop_count);
		note_error();
	end
endtask

`endif

// ==== tb_sccb_rx.sv ====
`default_nettype none

module tb_sccb_rx import sccb_rx_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	// DUT ports
	logic rx_clk;
	logic rst;
	serdes_word_t rx_in;
	logic rx_data_valid;
	ll_word_t rx_ll;
	logic rx_ll_link_up;
	logic rx_ll_commit;
	logic rx_ll_drop;

	// Test data with one entry per data file line
	string name_q[$];
	int count_q[$];
	serdes_word_t word_q[$];
	logic [2:0] nvalid_q[$];
	logic [31:0] data_q[$];
	int end_q[$];
	int link_q[$];

	// Expectation for the word the DUT took at the last edge
	string pend_name;
	ll_word_t pend_ll;
	int pend_link;

	// Run state
	string cur_name;
	logic in_frame;
	int seed;
	int cycle_count;
	int cycle_limit;
	int commit_count;
	int drop_count;
	int exp_commits;
	int exp_drops;
	int err_total;
	int test_errors;
	int tests_run;
	int tests_failed;

	////////////////////////////////////////
	// Clock, DUT and timeout

	initial begin
		rx_clk = 1'b0;
	end

	// 20 ns period
	always #10 rx_clk = ~rx_clk;

	sccb_rx_top sccb_rx_top_inst (
		.rx_clk        (rx_clk),
		.rst           (rst),
		.rx_in         (rx_in),
		.rx_data_valid (rx_data_valid),
		.rx_ll         (rx_ll),
		.rx_ll_link_up (rx_ll_link_up),
		.rx_ll_commit  (rx_ll_commit),
		.rx_ll_drop    (rx_ll_drop)
	);

	// Limit is armed once the data file is read
	always @(posedge rx_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("timeout after %0d cycles, the run did not reach its end", cycle_count);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// One clock of stimulus
	// Outputs at the falling edge belong to the word taken at the rising edge
	task automatic drive_cycle(input serdes_word_t word, input logic valid,
		input ll_word_t ll_exp, input int link_exp);
		@(posedge rx_clk);
		rx_in <= word;
		rx_data_valid <= valid;
		@(negedge rx_clk);
		check_ll(pend_name, pend_ll, rx_ll);
		// Link 2 means not checked on this word
		if (pend_link != 2) begin
			check_bit(pend_name, "link_up", pend_link == 1, rx_ll_link_up);
		end
		if (rx_ll_commit === 1'b1) begin
			commit_count++;
		end
		if (rx_ll_drop === 1'b1) begin
			drop_count++;
		end
		pend_name = cur_name;
		pend_ll = ll_exp;
		pend_link = link_exp;
	endtask

	`include "tb_sccb_rx_tasks.svh"

	////////////////////////////////////////
	// Stimulus

	initial begin
		int fd;
		int n;
		int total_words;
		int ngap;
		string line;
		string t_name;
		int t_count;
		logic [3:0] t_kchar;
		logic [31:0] t_data;
		int t_nvalid;
		logic [31:0] t_exp;
		int t_end;
		int t_link;
		serdes_word_t w;
		ll_word_t exp_ll;

		// Inputs quiet while reset is held
		rst = 1'b1;
		rx_in = '0;
		rx_data_valid = 1'b0;
		seed = 32'hbd86b2ff;
		cycle_count = 0;
		cycle_limit = 0;
		commit_count = 0;
		drop_count = 0;
		exp_commits = 0;
		exp_drops = 0;
		err_total = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		cur_name = "reset_state";
		pend_name = "reset_state";
		pend_ll = '0;
		pend_link = 2;
		in_frame = 1'b0;
		total_words = 0;

		// Load every word up front and skip comment lines that do not scan
		fd = $fopen("sccb_rx_testdata.txt", "r");
		if (fd == 0) begin
			$display("cannot open sccb_rx_testdata.txt, no words to send");
			note_error();
		end else begin
			while ($fgets(line, fd) != 0) begin
				n = $sscanf(line, "%s %d %h %h %d %h %d %d", t_name, t_count, t_kchar,
					t_data, t_nvalid, t_exp, t_end, t_link);
				if (n == 8) begin
					w.kchar = t_kchar;
					w.data = t_data;
					name_q.push_back(t_name);
					count_q.push_back(t_count);
					word_q.push_back(w);
					nvalid_q.push_back(3'(t_nvalid));
					data_q.push_back(t_exp);
					end_q.push_back(t_end);
					link_q.push_back(t_link);
					total_words += t_count;
				end
			end
			$fclose(fd);
		end
		cycle_limit = 300 + 8 * total_words;

		// Ten rising edges in reset
		repeat (10) @(posedge rx_clk);
		rst <= 1'b0;
		@(negedge rx_clk);
		check_ll("reset_state", '0, rx_ll);
		check_bit("reset_state", "link_up", 1'b0, rx_ll_link_up);
		check_bit("reset_state", "commit", 1'b0, rx_ll_commit);
		check_bit("reset_state", "drop", 1'b0, rx_ll_drop);
		finish_test("reset_state");

		for (int i = 0; i < name_q.size(); i++) begin
			cur_name = name_q[i];
			for (int r = 0; r < count_q[i]; r++) begin
				// First payload word of a frame carries start
				exp_ll = '0;
				if (nvalid_q[i] != 3'd0) begin
					exp_ll.start = !in_frame;
					exp_ll.valid = 1'b1;
					exp_ll.nvalid = nvalid_q[i];
					exp_ll.data = data_q[i];
					in_frame = 1'b1;
				end
				drive_cycle(word_q[i], 1'b1, exp_ll, (r == count_q[i] - 1) ? link_q[i] : 2);
			end
			if (end_q[i] != 0) begin
				check_end(cur_name, end_q[i]);
				in_frame = 1'b0;
				// Random idle gap before the next frame
				ngap = $random(seed) & 3;
				repeat (ngap) drive_cycle('0, 1'b0, '0, 2);
			end
			if (i == name_q.size() - 1 || name_q[i + 1] != cur_name) begin
				// One quiet cycle drains the last check of the test
				drive_cycle('0, 1'b0, '0, 2);
				finish_test(cur_name);
			end
		end

		check_totals();
		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			tests_run, tests_run - tests_failed, tests_failed, err_total);
		if (err_total == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
